/* Makefile */
# Verilator flow for the serial bus master
# variables can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= tb_bus_master
RTL_TOP    ?= bus_master
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -j 0
FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -qF -- '$(FAIL_MSG)' $(LOG) || ! grep -qF -- '$(PASS_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bus_master.sv */
// top level of the serial bus master
// connects the line decoder, the transaction sequencer and the shift unit
// the shared serial line is split into bus_in, bus_out and bus_oe
`timescale 1ns/1ns

module bus_master
    import bus_master_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     hold,
    input  logic     execute,
    input  bus_cmd_t cmd,
    input  logic     grant,
    input  logic     bus_in,
    output logic     request,
    output logic     busy,
    output logic     dvalid,
    output data_t    rdata,
    output logic     bus_out,
    output logic     bus_oe
);

    line_event_t line_event;
    shift_ctrl_t shift_ctrl;
    logic        arm;
    logic        tx_done;
    logic        rx_done;

    line_decode line_decode_i (
        .clk        (clk),
        .rstn       (rstn),
        .bus_in     (bus_in),
        .arm        (arm),
        .line_event (line_event)
    );

    bus_sequencer bus_sequencer_i (
        .clk        (clk),
        .rstn       (rstn),
        .hold       (hold),
        .execute    (execute),
        .grant      (grant),
        .cmd        (cmd),
        .line_event (line_event),
        .tx_done    (tx_done),
        .rx_done    (rx_done),
        .arm        (arm),
        .shift_ctrl (shift_ctrl),
        .request    (request),
        .busy       (busy),
        .dvalid     (dvalid)
    );

    shift_unit shift_unit_i (
        .clk        (clk),
        .rstn       (rstn),
        .shift_ctrl (shift_ctrl),
        .bus_in     (bus_in),
        .bus_out    (bus_out),
        .bus_oe     (bus_oe),
        .tx_done    (tx_done),
        .rx_done    (rx_done),
        .rdata      (rdata)
    );

endmodule

/* bus_master_pkg.sv */
// shared widths, types and encodings for the serial bus master
// each design file pulls this in by a wildcard import in its module header
package bus_master_pkg;

    localparam int ADDR_W = 12;                  // address frame width
    localparam int DATA_W = 8;                   // data byte width
    localparam int CNT_W  = $clog2(ADDR_W + 1);  // bit counter reaches ADDR_W

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] frame_t;          // a data byte sits in the top DATA_W bits

    // transaction sequencer states
    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_REQUEST    = 4'd1,
        ST_GRANTED    = 4'd2,
        ST_ADDR_SEND  = 4'd3,
        ST_ADDR_ACK   = 4'd4,
        ST_WRITE_SEND = 4'd5,
        ST_DATA_ACK   = 4'd6,
        ST_READ_START = 4'd7,
        ST_READ_DATA  = 4'd8
    } seq_state_t;

    // patterns seen on the serial line, previous sample then current sample
    typedef enum logic [1:0] {
        EV_NONE      = 2'd0,
        EV_ADDR_ACK  = 2'd1,  // low, low
        EV_DATA_MARK = 2'd2   // low, high
    } line_event_t;

    // command from the local module, sampled with execute
    typedef struct packed {
        logic  write;  // 1 writes wdata, 0 reads a byte
        addr_t addr;
        data_t wdata;
    } bus_cmd_t;

    // sequencer to shift unit
    typedef struct packed {
        logic             load;    // one cycle, starts a transmit
        logic             listen;  // level, receive while high
        logic [CNT_W-1:0] length;  // bits to move
        frame_t           word;    // frame to transmit, msb first
    } shift_ctrl_t;

endpackage

/* bus_sequencer.sv */
// transaction sequencer of the bus master
// requests the bus, then runs address, acknowledge and the write or read phase
// for every execute strobe that arrives while the bus is granted
`timescale 1ns/1ns

module bus_sequencer
    import bus_master_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        hold,
    input  logic        execute,
    input  logic        grant,
    input  bus_cmd_t    cmd,
    input  line_event_t line_event,
    input  logic        tx_done,
    input  logic        rx_done,
    output logic        arm,
    output shift_ctrl_t shift_ctrl,
    output logic        request,
    output logic        busy,
    output logic        dvalid
);

    seq_state_t state;
    bus_cmd_t   cmd_q;
    logic       load_q;
    logic       listen_q;
    logic       start_txn;
    logic       waiting;
    logic       addr_hit;
    logic       mark_hit;

    assign start_txn = (state == ST_GRANTED) && hold && grant && execute;

    assign waiting  = (state == ST_ADDR_ACK) || (state == ST_DATA_ACK) ||
                      (state == ST_READ_START);
    assign addr_hit = (state == ST_ADDR_ACK) && (line_event == EV_ADDR_ACK);
    assign mark_hit = ((state == ST_DATA_ACK) || (state == ST_READ_START)) &&
                      (line_event == EV_DATA_MARK);

    // disarm on the hit edge so the next wait phase starts from a clean line history
    assign arm = waiting && !addr_hit && !mark_hit;

    always_comb
    begin
        shift_ctrl.load   = load_q;
        shift_ctrl.listen = listen_q;
        shift_ctrl.length = (state == ST_ADDR_SEND) ? CNT_W'(ADDR_W) : CNT_W'(DATA_W);
        shift_ctrl.word   = (state == ST_WRITE_SEND) ?
                            {cmd_q.wdata, {(ADDR_W-DATA_W){1'b0}}} : cmd_q.addr;
    end

    always_ff @(posedge clk)
    begin
        if (start_txn)
        begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= ST_IDLE;
            request  <= 1'b0;
            busy     <= 1'b0;
            dvalid   <= 1'b0;
            load_q   <= 1'b0;
            listen_q <= 1'b0;
        end
        else
        begin
            dvalid <= 1'b0;  // pulse
            load_q <= 1'b0;  // pulse

            case (state)
                ST_IDLE:
                begin
                    if (hold)
                    begin
                        request <= 1'b1;
                        busy    <= 1'b1;
                        state   <= ST_REQUEST;
                    end
                end

                ST_REQUEST:
                begin
                    if (grant)
                    begin
                        busy  <= 1'b0;  // ready for execute
                        state <= ST_GRANTED;
                    end
                end

                ST_GRANTED:
                begin
                    if (!hold)
                    begin
                        request <= 1'b0;  // release the bus
                        state   <= ST_IDLE;
                    end
                    else if (!grant)
                    begin
                        busy  <= 1'b1;
                        state <= ST_REQUEST;
                    end
                    else if (execute)
                    begin
                        busy   <= 1'b1;
                        load_q <= 1'b1;  // address frame
                        state  <= ST_ADDR_SEND;
                    end
                end

                ST_ADDR_SEND:
                begin
                    if (tx_done)
                    begin
                        state <= ST_ADDR_ACK;
                    end
                end

                ST_ADDR_ACK:
                begin
                    if (addr_hit)
                    begin
                        if (cmd_q.write)
                        begin
                            load_q <= 1'b1;  // data byte
                            state  <= ST_WRITE_SEND;
                        end
                        else
                        begin
                            state <= ST_READ_START;
                        end
                    end
                end

                ST_WRITE_SEND:
                begin
                    if (tx_done)
                    begin
                        state <= ST_DATA_ACK;
                    end
                end

                ST_DATA_ACK:
                begin
                    if (mark_hit)
                    begin
                        dvalid <= 1'b1;
                        busy   <= 1'b0;
                        state  <= ST_GRANTED;
                    end
                end

                ST_READ_START:
                begin
                    if (mark_hit)
                    begin
                        listen_q <= 1'b1;  // data follows the start mark directly
                        state    <= ST_READ_DATA;
                    end
                end

                ST_READ_DATA:
                begin
                    if (rx_done)
                    begin
                        listen_q <= 1'b0;
                        dvalid   <= 1'b1;
                        busy     <= 1'b0;
                        state    <= ST_GRANTED;
                    end
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* filelist.f */
bus_master_pkg.sv
line_decode.sv
shift_unit.sv
bus_sequencer.sv
bus_master.sv
tb_bus_master.sv

/* line_decode.sv */
// serial line pattern decoder for the bus master
// keeps the previous line sample and flags the acknowledge and start patterns
// the previous sample is forced high while disarmed, so a hit needs two fresh samples
`timescale 1ns/1ns

module line_decode
    import bus_master_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        bus_in,
    input  logic        arm,
    output line_event_t line_event
);

    logic prev_bit;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            prev_bit <= 1'b1;
        end
        else if (!arm)
        begin
            prev_bit <= 1'b1;  // idle line level
        end
        else
        begin
            prev_bit <= bus_in;
        end
    end

    always_comb
    begin
        line_event = EV_NONE;
        if (!prev_bit)
        begin
            line_event = bus_in ? EV_DATA_MARK : EV_ADDR_ACK;
        end
    end

endmodule

/* shift_unit.sv */
// shift unit of the bus master
// transmits a frame msb first on a load pulse and receives a byte while listen is high
// the last received byte stays in rdata until the next receive completes
`timescale 1ns/1ns

module shift_unit
    import bus_master_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  shift_ctrl_t shift_ctrl,
    input  logic        bus_in,
    output logic        bus_out,
    output logic        bus_oe,
    output logic        tx_done,
    output logic        rx_done,
    output data_t       rdata
);

    frame_t           shreg;
    frame_t           shreg_in;
    logic [CNT_W-1:0] bit_cnt;
    logic             tx_run;
    logic             last_bit;

    assign last_bit = (bit_cnt == shift_ctrl.length - 1'b1);
    assign shreg_in = {shreg[ADDR_W-2:0], bus_in};  // receive enters at the lsb

    assign tx_done = tx_run && last_bit;                       // with the last bit on the line
    assign rx_done = shift_ctrl.listen && !tx_run && last_bit;  // last bit being sampled

    assign bus_oe  = tx_run;
    assign bus_out = tx_run & shreg[ADDR_W-1];

    // transmit flag and the shared bit counter
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            tx_run  <= 1'b0;
            bit_cnt <= '0;
        end
        else if (shift_ctrl.load)
        begin
            tx_run  <= 1'b1;
            bit_cnt <= '0;
        end
        else if (tx_run || shift_ctrl.listen)
        begin
            if (last_bit)
            begin
                tx_run  <= 1'b0;
                bit_cnt <= '0;
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
        else
        begin
            bit_cnt <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (shift_ctrl.load)
        begin
            shreg <= shift_ctrl.word;
        end
        else if (tx_run)
        begin
            shreg <= {shreg[ADDR_W-2:0], 1'b0};  // next bit to the top
        end
        else if (shift_ctrl.listen)
        begin
            shreg <= shreg_in;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            rdata <= '0;
        end
        else if (rx_done)
        begin
            rdata <= shreg_in[DATA_W-1:0];
        end
    end

endmodule

/* tb_bus_master.sv */
// testbench for the serial bus master
// random writes and reads against a slave and arbiter model, random bits from a seeded LFSR
// stops at the first mismatch, and a watchdog bounds the run time
`timescale 1ns/1ns

module tb_bus_master
    import bus_master_pkg::*;
();

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_TXN        = 200;                     // back-to-back under one grant
    localparam int WATCHDOG_NS  = (N_TXN + 1) * 120 * CLK_NS + RESET_CYCLES * CLK_NS;

    logic        clk = 1'b0;
    logic        rstn;
    logic        hold;
    logic        execute;
    bus_cmd_t    cmd;
    logic        grant;
    logic        bus_in;
    logic        request;
    logic        busy;
    logic        dvalid;
    data_t       rdata;
    logic        bus_out;
    logic        bus_oe;
    logic [15:0] lfsr_state = 16'd82;
    int          n_write = 0;
    int          n_read  = 0;

    bus_master bus_master_i (
        .clk     (clk),
        .rstn    (rstn),
        .hold    (hold),
        .execute (execute),
        .cmd     (cmd),
        .grant   (grant),
        .bus_in  (bus_in),
        .request (request),
        .busy    (busy),
        .dvalid  (dvalid),
        .rdata   (rdata),
        .bus_out (bus_out),
        .bus_oe  (bus_oe)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // galois lfsr, one step per random bit, taps 16,14,13,11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Error: %s is 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            $display("Error: %s is 0x%03h, expected 0x%03h at %0t ns", name, got, exp, $time);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("Error: %s is 0x%02h, expected 0x%02h at %0t ns", name, got, exp, $time);
            stop_with_failure();
        end
    endtask

    // inputs change 1 ns after the rising edge, outputs are read right after that
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_quiet();
        check_flag("request", request, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("dvalid", dvalid, 1'b0);
        check_flag("bus_oe", bus_oe, 1'b0);
    endtask

    task automatic wait_for_oe(input int limit);
        int n;
        n = 0;
        while (!bus_oe)
        begin
            check_flag("dvalid", dvalid, 1'b0);
            if (n == limit)
            begin
                $display("bus_oe did not rise within %0d cycles at %0t ns", limit, $time);
                stop_with_failure();
            end
            next_cycle();
            n++;
        end
    endtask

    // slave side capture of one outgoing frame, msb first
    task automatic capture_frame(input int len, output frame_t bits);
        bits = '0;
        for (int i = 0; i < len; i++)
        begin
            check_flag("bus_oe", bus_oe, 1'b1);
            check_flag("dvalid", dvalid, 1'b0);
            bits = {bits[ADDR_W-2:0], bus_out};
            next_cycle();
        end
        check_flag("bus_oe", bus_oe, 1'b0);  // frame is exactly len bits long
    endtask

    task automatic send_bit(input logic b);
        bus_in = b;
        next_cycle();
        check_flag("bus_oe", bus_oe, 1'b0);  // master never drives while the slave talks
    endtask

    task automatic idle_line(input int n);
        for (int i = 0; i < n; i++)
        begin
            send_bit(1'b1);
            check_flag("dvalid", dvalid, 1'b0);
        end
    endtask

    task automatic acquire_bus();
        int gap;
        gap  = int'(rand_bits(3));
        hold = 1'b1;
        next_cycle();
        check_flag("request", request, 1'b1);
        check_flag("busy", busy, 1'b1);
        for (int i = 0; i < gap; i++)  // arbiter delay
        begin
            next_cycle();
            check_flag("request", request, 1'b1);
            check_flag("busy", busy, 1'b1);
        end
        grant = 1'b1;
        next_cycle();
        check_flag("busy", busy, 1'b0);
        check_flag("request", request, 1'b1);
    endtask

    task automatic release_bus();
        hold = 1'b0;
        next_cycle();
        check_quiet();
        grant = 1'b0;  // arbiter takes the grant back
        for (int i = 0; i < 8; i++)
        begin
            next_cycle();
            check_quiet();
        end
    endtask

    task automatic run_transaction();
        bus_cmd_t c;
        data_t    slave_byte;
        data_t    sr;
        int       ack_gap;
        int       mark_gap;
        frame_t   seen;
        c.write    = 1'(rand_bits(1));
        c.addr     = addr_t'(rand_bits(ADDR_W));
        c.wdata    = data_t'(rand_bits(DATA_W));
        slave_byte = data_t'(rand_bits(DATA_W));
        ack_gap    = int'(rand_bits(3));
        mark_gap   = int'(rand_bits(3));

        cmd     = c;
        execute = 1'b1;
        next_cycle();
        execute = 1'b0;
        cmd     = '0;
        check_flag("busy", busy, 1'b1);
        wait_for_oe(4);
        capture_frame(ADDR_W, seen);
        check_addr("bus_out address frame", seen, c.addr);

        idle_line(ack_gap);
        send_bit(1'b0);
        send_bit(1'b0);  // address acknowledge, two lows
        bus_in = 1'b1;

        if (c.write)
        begin
            wait_for_oe(2);
            capture_frame(DATA_W, seen);
            check_data("bus_out write data", seen[DATA_W-1:0], c.wdata);
            idle_line(mark_gap);
            send_bit(1'b0);
            check_flag("dvalid", dvalid, 1'b0);
            send_bit(1'b1);  // data acknowledge, low then high
            check_flag("dvalid", dvalid, 1'b1);
            n_write++;
        end
        else
        begin
            idle_line(mark_gap);
            send_bit(1'b0);
            send_bit(1'b1);  // start mark
            sr = slave_byte;
            for (int i = 0; i < DATA_W; i++)
            begin
                check_flag("dvalid", dvalid, 1'b0);
                send_bit(sr[DATA_W-1]);
                sr = sr << 1;
            end
            bus_in = 1'b1;
            check_flag("dvalid", dvalid, 1'b1);
            check_data("rdata", rdata, slave_byte);
            n_read++;
        end

        check_flag("busy", busy, 1'b0);
        next_cycle();
        check_flag("dvalid", dvalid, 1'b0);  // one pulse only
        check_flag("request", request, 1'b1);
    endtask

    initial
    begin
        rstn    = 1'b0;
        hold    = 1'b0;
        execute = 1'b0;
        cmd     = '0;
        grant   = 1'b0;
        bus_in  = 1'b1;

        repeat (RESET_CYCLES)
        begin
            next_cycle();
            check_quiet();
        end
        rstn = 1'b1;
        next_cycle();
        check_quiet();
        check_data("rdata", rdata, '0);

        acquire_bus();
        for (int t = 0; t < N_TXN; t++)
        begin
            run_transaction();
        end
        release_bus();

        acquire_bus();  // request again after a release
        run_transaction();
        release_bus();

        $display("%0d writes and %0d reads checked", n_write, n_read);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        stop_with_failure();
    end

endmodule
